//--- mips_pkg.sv
// shared types for the MIPS I subset core; both memories are fixed at 256 words, no parameters.
`default_nettype none

package mips_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sizes and constants
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 256;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [7:0]  imem_addr_t;
    typedef logic [7:0]  dmem_addr_t;

    localparam word_t RESET_PC = 32'h0000_0000;
    localparam word_t NOP      = 32'h0000_0000; // sll $0, $0, 0.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_BEQ     = 6'h04,
        OP_ADDIU   = 6'h09,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_SLL
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_REG, // register file value.
        FWD_MEM, // memory stage result.
        FWD_WB   // writeback data.
    } fwd_sel_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage-to-stage records
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        word_t instr;
        word_t pc4;
    } if_id_t;

    typedef struct packed {
        logic      valid;
        logic      reg_wr;
        logic      mem_rd;
        logic      mem_wr;
        logic      branch;
        logic      jump;
        logic      use_imm;
        alu_op_e   alu_op;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t dst;
        word_t     rs_data;
        word_t     rt_data;
        word_t     imm;
        logic [4:0] shamt;
        word_t     jump_tgt;
        word_t     next_pc;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        logic      reg_wr;
        logic      mem_rd;
        logic      mem_wr;
        reg_addr_t dst;
        word_t     result;
        word_t     store_data;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t dst;
        word_t     data;
    } retire_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

endpackage

`default_nettype wire

//--- mips_fetch.sv
// fetch stage; instruction RAM is filled only through the load port, meant for use during reset.
`timescale 1ns/10ps
`default_nettype none

module mips_fetch (
    input  wire                   clk,
    input  wire                   arst_n_i,
    input  wire                   stall_i,
    input  wire                   flush_i,
    input  mips_pkg::redirect_t   redirect_i,
    input  wire                   load_we_i,
    input  mips_pkg::imem_addr_t  load_addr_i,
    input  mips_pkg::word_t       load_data_i,
    output mips_pkg::if_id_t      if_id_o
);
    import mips_pkg::*;

    word_t      imem [IMEM_WORDS];
    word_t      pc_q;
    word_t      pc4;
    imem_addr_t pc_idx;
    if_id_t     if_id_q;

    assign pc4    = pc_q + 32'd4;
    assign pc_idx = pc_q[9:2]; // word index.

    always_ff @(posedge clk) begin
        if (load_we_i)
            imem[load_addr_i] <= load_data_i;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q    <= RESET_PC;
            if_id_q <= '0;
        end else begin
            if (redirect_i.taken)
                pc_q <= redirect_i.target; // redirect beats stall.
            else if (!stall_i)
                pc_q <= pc4;

            if (flush_i)
                if_id_q <= '{instr: NOP, pc4: '0};
            else if (!stall_i)
                if_id_q <= '{instr: imem[pc_idx], pc4: pc4};
        end
    end

    assign if_id_o = if_id_q;

endmodule

`default_nettype wire

//--- mips_decode.sv
// decode stage; unknown opcodes and funct codes decode to a harmless no-write entry.
`timescale 1ns/10ps
`default_nettype none

module mips_decode (
    input  wire                  clk,
    input  wire                  arst_n_i,
    input  wire                  stall_i,
    input  wire                  bubble_i,
    input  wire                  flush_i,
    input  mips_pkg::if_id_t     if_id_i,
    input  mips_pkg::word_t      rs_data_i,
    input  mips_pkg::word_t      rt_data_i,
    output mips_pkg::reg_addr_t  rs_addr_o,
    output mips_pkg::reg_addr_t  rt_addr_o,
    output mips_pkg::id_ex_t     id_ex_o
);
    import mips_pkg::*;

    opcode_e   opcode;
    funct_e    funct;
    reg_addr_t rs, rt, rd;
    logic      is_sll;
    id_ex_t    dec;
    id_ex_t    id_ex_q;

    assign opcode = opcode_e'(if_id_i.instr[31:26]);
    assign funct  = funct_e'(if_id_i.instr[5:0]);
    assign rs     = if_id_i.instr[25:21];
    assign rt     = if_id_i.instr[20:16];
    assign rd     = if_id_i.instr[15:11];
    assign is_sll = (opcode == OP_SPECIAL) && (funct == F_SLL);

    // sll shifts rt, so rt becomes the first operand.
    assign rs_addr_o = is_sll ? rt : rs;
    assign rt_addr_o = rt;

    always_comb begin
        dec          = '0;
        dec.valid    = 1'b1;
        dec.rs       = rs_addr_o;
        dec.rt       = rt;
        dec.rs_data  = rs_data_i;
        dec.rt_data  = rt_data_i;
        dec.imm      = {{16{if_id_i.instr[15]}}, if_id_i.instr[15:0]};
        dec.shamt    = if_id_i.instr[10:6];
        dec.jump_tgt = {if_id_i.pc4[31:28], if_id_i.instr[25:0], 2'b00};
        dec.next_pc  = if_id_i.pc4;
        dec.alu_op   = ALU_ADD;
        case (opcode)
            OP_SPECIAL: begin
                dec.reg_wr = 1'b1;
                dec.dst    = rd;
                case (funct)
                    F_ADDU:  dec.alu_op = ALU_ADD;
                    F_SUBU:  dec.alu_op = ALU_SUB;
                    F_AND:   dec.alu_op = ALU_AND;
                    F_OR:    dec.alu_op = ALU_OR;
                    F_SLT:   dec.alu_op = ALU_SLT;
                    F_SLL:   dec.alu_op = ALU_SLL;
                    default: dec.reg_wr = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                dec.reg_wr  = 1'b1;
                dec.use_imm = 1'b1;
                dec.dst     = rt;
            end
            OP_LW: begin
                dec.reg_wr  = 1'b1;
                dec.mem_rd  = 1'b1;
                dec.use_imm = 1'b1;
                dec.dst     = rt;
            end
            OP_SW: begin
                dec.mem_wr  = 1'b1;
                dec.use_imm = 1'b1;
            end
            OP_BEQ:  dec.branch = 1'b1;
            OP_J:    dec.jump   = 1'b1;
            default: dec.valid  = 1'b0;
        endcase
        if (dec.dst == 5'd0)
            dec.reg_wr = 1'b0; // writes to $0 vanish here.
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i)
            id_ex_q <= '0;
        else if (bubble_i || flush_i || stall_i)
            id_ex_q <= '0; // bubble.
        else
            id_ex_q <= dec;
    end

    assign id_ex_o = id_ex_q;

endmodule

`default_nettype wire

//--- mips_regfile.sv
// register file; reads are combinational and see a write landing in the same cycle.
`timescale 1ns/10ps
`default_nettype none

module mips_regfile (
    input  wire                  clk,
    input  wire                  arst_n_i,
    input  mips_pkg::reg_addr_t  rs_addr_i,
    input  mips_pkg::reg_addr_t  rt_addr_i,
    input  mips_pkg::retire_t    wr_i,
    output mips_pkg::word_t      rs_data_o,
    output mips_pkg::word_t      rt_data_o
);
    import mips_pkg::*;

    word_t regs [1:31];
    logic  wr_en;

    assign wr_en = wr_i.valid && (wr_i.dst != 5'd0);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (wr_en) begin
            regs[wr_i.dst] <= wr_i.data;
        end
    end

    function automatic word_t read_port(reg_addr_t addr);
        if (addr == 5'd0)
            return '0;
        else if (wr_en && (wr_i.dst == addr))
            return wr_i.data; // write-before-read.
        else
            return regs[addr];
    endfunction

    always_comb begin
        rs_data_o = read_port(rs_addr_i);
        rt_data_o = read_port(rt_addr_i);
    end

endmodule

`default_nettype wire

//--- mips_execute.sv
// execute stage; branches and jumps resolve here, so the redirect is combinational from id_ex.
`timescale 1ns/10ps
`default_nettype none

module mips_execute (
    input  wire                  clk,
    input  wire                  arst_n_i,
    input  mips_pkg::id_ex_t     id_ex_i,
    input  mips_pkg::fwd_sel_e   fwd_a_i,
    input  mips_pkg::fwd_sel_e   fwd_b_i,
    input  mips_pkg::word_t      mem_fwd_i,
    input  mips_pkg::retire_t    wb_fwd_i,
    output mips_pkg::ex_mem_t    ex_mem_o,
    output mips_pkg::redirect_t  redirect_o
);
    import mips_pkg::*;

    word_t   op_a, op_b, alu_b, alu_res, br_tgt;
    ex_mem_t ex_mem_q;

    function automatic word_t fwd_mux(fwd_sel_e sel, word_t reg_val);
        case (sel)
            FWD_MEM: return mem_fwd_i;
            FWD_WB:  return wb_fwd_i.data;
            default: return reg_val;
        endcase
    endfunction

    always_comb begin
        op_a  = fwd_mux(fwd_a_i, id_ex_i.rs_data);
        op_b  = fwd_mux(fwd_b_i, id_ex_i.rt_data);
        alu_b = id_ex_i.use_imm ? id_ex_i.imm : op_b;
        case (id_ex_i.alu_op)
            ALU_SUB: alu_res = op_a - alu_b;
            ALU_AND: alu_res = op_a & alu_b;
            ALU_OR:  alu_res = op_a | alu_b;
            ALU_SLT: alu_res = {31'd0, $signed(op_a) < $signed(alu_b)};
            ALU_SLL: alu_res = op_a << id_ex_i.shamt; // op_a holds rt here.
            default: alu_res = op_a + alu_b;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // branch and jump resolution
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign br_tgt = id_ex_i.next_pc + {id_ex_i.imm[29:0], 2'b00};

    assign redirect_o.taken  = id_ex_i.valid &&
                               (id_ex_i.jump || (id_ex_i.branch && (op_a == op_b)));
    assign redirect_o.target = id_ex_i.jump ? id_ex_i.jump_tgt : br_tgt;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_mem_q <= '0;
        end else begin
            ex_mem_q.valid      <= id_ex_i.valid;
            ex_mem_q.reg_wr     <= id_ex_i.valid && id_ex_i.reg_wr;
            ex_mem_q.mem_rd     <= id_ex_i.valid && id_ex_i.mem_rd;
            ex_mem_q.mem_wr     <= id_ex_i.valid && id_ex_i.mem_wr;
            ex_mem_q.dst        <= id_ex_i.dst;
            ex_mem_q.result     <= alu_res;
            ex_mem_q.store_data <= op_b;
        end
    end

    assign ex_mem_o = ex_mem_q;

endmodule

`default_nettype wire

//--- mips_hazard_unit.sv
// hazard unit; combinational, also takes the execute-stage sources for the forwarding compare.
`timescale 1ns/10ps
`default_nettype none

module mips_hazard_unit (
    input  mips_pkg::reg_addr_t  dec_rs_i,
    input  mips_pkg::reg_addr_t  dec_rt_i,
    input  mips_pkg::reg_addr_t  ex_rs_i,
    input  mips_pkg::reg_addr_t  ex_rt_i,
    input  mips_pkg::reg_addr_t  ex_dst_i,
    input  mips_pkg::reg_addr_t  mem_dst_i,
    input  mips_pkg::reg_addr_t  wb_dst_i,
    input  wire                  ex_mem_rd_i,
    input  wire                  mem_reg_wr_i,
    input  wire                  wb_valid_i,
    input  wire                  taken_i,
    output logic                 stall_o,
    output logic                 bubble_o,
    output logic                 flush_o,
    output mips_pkg::fwd_sel_e   fwd_a_o,
    output mips_pkg::fwd_sel_e   fwd_b_o
);
    import mips_pkg::*;

    logic load_use;

    // memory stage is younger, so it wins over writeback.
    function automatic fwd_sel_e pick(reg_addr_t src);
        if (src == 5'd0)
            return FWD_REG;
        else if (mem_reg_wr_i && (mem_dst_i == src))
            return FWD_MEM;
        else if (wb_valid_i && (wb_dst_i == src))
            return FWD_WB;
        else
            return FWD_REG;
    endfunction

    always_comb begin
        fwd_a_o = pick(ex_rs_i);
        fwd_b_o = pick(ex_rt_i);
    end

    assign load_use = ex_mem_rd_i && (ex_dst_i != 5'd0) &&
                      ((ex_dst_i == dec_rs_i) || (ex_dst_i == dec_rt_i));

    assign stall_o  = load_use;
    assign flush_o  = taken_i;
    assign bubble_o = load_use || taken_i;

endmodule

`default_nettype wire

//--- mips_mem_stage.sv
// memory stage; word accesses only, address bits 1:0 and above bit 9 are ignored.
`timescale 1ns/10ps
`default_nettype none

module mips_mem_stage (
    input  wire                clk,
    input  wire                arst_n_i,
    input  mips_pkg::ex_mem_t  ex_mem_i,
    output mips_pkg::word_t    mem_fwd_o,
    output mips_pkg::retire_t  retire_o
);
    import mips_pkg::*;

    word_t      dmem [DMEM_WORDS];
    dmem_addr_t addr;
    retire_t    retire_q;

    assign addr = ex_mem_i.result[9:2];

    always_ff @(posedge clk) begin
        if (ex_mem_i.mem_wr)
            dmem[addr] <= ex_mem_i.store_data;
    end

    assign mem_fwd_o = ex_mem_i.mem_rd ? dmem[addr] : ex_mem_i.result; // async read.

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            retire_q <= '0;
        end else begin
            retire_q.valid <= ex_mem_i.reg_wr && (ex_mem_i.dst != 5'd0);
            retire_q.dst   <= ex_mem_i.dst;
            retire_q.data  <= mem_fwd_o;
        end
    end

    assign retire_o = retire_q;

endmodule

`default_nettype wire

//--- mips_core_top.sv
// core top; load port is for reset time only, every register write shows up on retire_o.
`timescale 1ns/10ps
`default_nettype none

module mips_core_top (
    input  wire                   clk,
    input  wire                   arst_n_i,
    input  wire                   load_we_i,
    input  mips_pkg::imem_addr_t  load_addr_i,
    input  mips_pkg::word_t       load_data_i,
    output mips_pkg::retire_t     retire_o
);
    import mips_pkg::*;

    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    retire_t   retire;
    redirect_t redirect;
    reg_addr_t rs_addr, rt_addr;
    word_t     rs_data, rt_data;
    word_t     mem_fwd;
    fwd_sel_e  fwd_a, fwd_b;
    logic      stall, bubble, flush;

    mips_fetch i_mips_fetch (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .stall_i     (stall),
        .flush_i     (flush),
        .redirect_i  (redirect),
        .load_we_i   (load_we_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i),
        .if_id_o     (if_id)
    );

    mips_decode i_mips_decode (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .stall_i   (stall),
        .bubble_i  (bubble),
        .flush_i   (flush),
        .if_id_i   (if_id),
        .rs_data_i (rs_data),
        .rt_data_i (rt_data),
        .rs_addr_o (rs_addr),
        .rt_addr_o (rt_addr),
        .id_ex_o   (id_ex)
    );

    mips_regfile i_mips_regfile (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .rs_addr_i (rs_addr),
        .rt_addr_i (rt_addr),
        .wr_i      (retire),
        .rs_data_o (rs_data),
        .rt_data_o (rt_data)
    );

    mips_execute i_mips_execute (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .id_ex_i    (id_ex),
        .fwd_a_i    (fwd_a),
        .fwd_b_i    (fwd_b),
        .mem_fwd_i  (mem_fwd),
        .wb_fwd_i   (retire),
        .ex_mem_o   (ex_mem),
        .redirect_o (redirect)
    );

    mips_hazard_unit i_mips_hazard_unit (
        .dec_rs_i     (rs_addr),
        .dec_rt_i     (rt_addr),
        .ex_rs_i      (id_ex.rs),
        .ex_rt_i      (id_ex.rt),
        .ex_dst_i     (id_ex.dst),
        .mem_dst_i    (ex_mem.dst),
        .wb_dst_i     (retire.dst),
        .ex_mem_rd_i  (id_ex.mem_rd),
        .mem_reg_wr_i (ex_mem.reg_wr),
        .wb_valid_i   (retire.valid),
        .taken_i      (redirect.taken),
        .stall_o      (stall),
        .bubble_o     (bubble),
        .flush_o      (flush),
        .fwd_a_o      (fwd_a),
        .fwd_b_o      (fwd_b)
    );

    mips_mem_stage i_mips_mem_stage (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .ex_mem_i  (ex_mem),
        .mem_fwd_o (mem_fwd),
        .retire_o  (retire)
    );

    assign retire_o = retire;

endmodule

`default_nettype wire

//--- mips_core_asserts.sv
// pipeline control checks, bound to the core top level where the hazard unit outputs are wired.
`timescale 1ns/10ps
`default_nettype none

module mips_core_asserts (
    input wire               clk,
    input wire               arst_n_i,
    input wire               stall_i,
    input wire               ex_valid_i,
    input wire               flush_i,
    input mips_pkg::retire_t retire_i
);

    // a held decode must not leak into execute.
    stall_has_bubble: assert property (@(posedge clk) disable iff (!arst_n_i)
        stall_i |=> !ex_valid_i)
        else $error("stall raised without bubble");

    no_flush_after_reset: assert property (@(posedge clk)
        $rose(arst_n_i) |-> !flush_i)
        else $error("flush in the first cycle after reset");

    no_retire_to_zero: assert property (@(posedge clk) disable iff (!arst_n_i)
        retire_i.valid |-> (retire_i.dst != 5'd0))
        else $error("retire wrote register zero");

endmodule

bind mips_core_top mips_core_asserts i_mips_core_asserts (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .stall_i    (stall),
    .ex_valid_i (id_ex.valid),
    .flush_i    (flush),
    .retire_i   (retire)
);

`default_nettype wire

//--- tb_mips_core.sv
// random-program testbench; programs are 16 words, loads and stores use RAM words 0 to 7 only.
`timescale 1ns/10ps
`default_nettype none

module tb_mips_core;
    import mips_pkg::*;

    logic       clk = 1'b0;
    logic       arst_n;
    logic       load_we;
    imem_addr_t load_addr;
    word_t      load_data;
    retire_t    retire;

    integer     seed;
    word_t      prog [16];
    word_t      dmem_model [256];
    reg_addr_t  exp_dst [$];
    word_t      exp_val [$];
    int         got_cnt;
    logic [5:0] functs [6] = '{6'h21, 6'h23, 6'h24, 6'h25, 6'h2a, 6'h00};

    always #20 clk = ~clk;

    mips_core_top i_mips_core_top (
        .clk         (clk),
        .arst_n_i    (arst_n),
        .load_we_i   (load_we),
        .load_addr_i (load_addr),
        .load_data_i (load_data),
        .retire_o    (retire)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reporting
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            abort_run("retire stream differs from the model");
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // program generation
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic word_t r_type(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
                                     logic [4:0] shamt, logic [5:0] funct);
        return {6'h00, rs, rt, rd, shamt, funct};
    endfunction

    function automatic word_t i_type(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
                                     logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // zeroes the data words that random programs use.
    task automatic make_clear_program();
        for (int i = 0; i < 16; i++)
            prog[i] = (i < 8) ? i_type(6'h2b, 5'd0, 5'd0, 16'(i * 4)) : 32'h0;
        prog[15] = i_type(6'h04, 5'd0, 5'd0, 16'hffff); // self-loop.
    endtask

    task automatic make_random_program();
        int         r;
        int         s;
        int         off;
        logic [5:0] fn;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        for (int i = 0; i < 15; i++) begin
            r   = $random(seed);
            s   = $random(seed);
            rs  = {2'b00, r[5:3]}; // few registers, many dependencies.
            rt  = {2'b00, r[8:6]};
            rd  = {2'b00, r[11:9]};
            fn  = functs[r[25:23] % 3'd6];
            off = {16'd0, s[15:0]} % (15 - i); // forward only.
            case (r[14:12])
                3'd2:    prog[i] = i_type(6'h09, rs, rt, s[15:0]);
                3'd3:    prog[i] = i_type(6'h23, 5'd0, rt, {11'd0, r[17:15], 2'b00});
                3'd4:    prog[i] = i_type(6'h2b, 5'd0, rt, {11'd0, r[17:15], 2'b00});
                3'd5:    prog[i] = i_type(6'h04, rs, rt, off[15:0]);
                3'd6:    prog[i] = {6'h02, 26'(i + 1 + off)};
                default: prog[i] = (fn == 6'h00) ? r_type(5'd0, rt, rd, r[22:18], fn)
                                                 : r_type(rs, rt, rd, 5'd0, fn);
            endcase
        end
        prog[15] = i_type(6'h04, 5'd0, 5'd0, 16'hffff);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction-set model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic model_run();
        word_t     regs [32];
        word_t     ins;
        word_t     a;
        word_t     b;
        word_t     ea;
        word_t     val;
        logic      wr;
        reg_addr_t dst;
        int        pc;
        int        next;
        for (int k = 0; k < 32; k++)
            regs[k] = '0;
        exp_dst.delete();
        exp_val.delete();
        pc = 0;
        while (pc != 15) begin
            ins  = prog[pc];
            a    = regs[ins[25:21]];
            b    = regs[ins[20:16]];
            ea   = a + {{16{ins[15]}}, ins[15:0]};
            next = pc + 1;
            wr   = 1'b0;
            dst  = ins[20:16];
            val  = '0;
            case (ins[31:26])
                6'h00: begin
                    wr  = 1'b1;
                    dst = ins[15:11];
                    case (ins[5:0])
                        6'h21:   val = a + b;
                        6'h23:   val = a - b;
                        6'h24:   val = a & b;
                        6'h25:   val = a | b;
                        6'h2a:   val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: val = b << ins[10:6]; // sll.
                    endcase
                end
                6'h09: begin
                    wr  = 1'b1;
                    val = ea;
                end
                6'h23: begin
                    wr  = 1'b1;
                    val = dmem_model[ea[9:2]];
                end
                6'h2b:   dmem_model[ea[9:2]] = b;
                6'h04:   next = (a == b) ? pc + 1 + int'($signed(ins[15:0])) : pc + 1;
                default: next = int'(ins[25:0]); // j.
            endcase
            if (wr && (dst != 5'd0)) begin
                regs[dst] = val;
                exp_dst.push_back(dst);
                exp_val.push_back(val);
            end
            pc = next;
        end
    endtask

    // retire checker, sampled away from the active edge.
    always @(negedge clk) begin
        if (arst_n && retire.valid) begin
            if (got_cnt >= exp_dst.size()) begin
                abort_run($sformatf("unexpected retire to register %0d", retire.dst));
            end else begin
                check_value("retire_o.dst", {27'd0, retire.dst}, {27'd0, exp_dst[got_cnt]});
                check_value("retire_o.data", retire.data, exp_val[got_cnt]);
                got_cnt++;
            end
        end
    end

    task automatic run_program();
        int waited;
        model_run();
        @(posedge clk);
        #2;
        arst_n  = 1'b0;
        got_cnt = 0;
        for (int i = 0; i < 16; i++) begin
            load_we   = 1'b1;
            load_addr = i[7:0];
            load_data = prog[i];
            @(posedge clk);
            #2;
        end
        load_we = 1'b0;
        arst_n  = 1'b1;
        waited  = 0;
        while (got_cnt < exp_dst.size()) begin
            @(posedge clk);
            waited++;
            if (waited > 200)
                abort_run($sformatf("timeout with %0d of %0d retires seen",
                                    got_cnt, exp_dst.size()));
        end
        repeat (20) @(posedge clk); // nothing more may retire.
    endtask

    initial begin
        seed      = 50;
        arst_n    = 1'b0;
        load_we   = 1'b0;
        load_addr = '0;
        load_data = '0;
        got_cnt   = 0;
        make_clear_program();
        run_program();
        for (int n = 0; n < 10; n++) begin
            make_random_program();
            run_program();
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
mips_pkg.sv
mips_fetch.sv
mips_decode.sv
mips_regfile.sv
mips_execute.sv
mips_hazard_unit.sv
mips_mem_stage.sv
mips_core_top.sv
mips_core_asserts.sv
tb_mips_core.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_mips_core
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
PASS_MSG  = ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulation passes only if the pass line shows up in its output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
